// File: files.f
hw/pipe_pkg.sv
hw/sample_fifo.sv
hw/pipe_start_fsm.sv
hw/pipe_segment.sv
hw/pipeline_gen.sv
tests/pipe_ref_model.sv
tests/pipeline_gen_tb.sv

// File: Makefile
# Verilator build for the trigger latency pipeline

VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = pipeline_gen_tb
RTL_TOP   = pipeline_gen
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

# Lint the design top, then the testbench top
lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# A failing run ends in $$fatal, so the binary exits non-zero
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/pipeline_gen_tb.sv
module pipeline_gen_tb import pipe_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_SEG   = 4;
	localparam int CLK_PER   = 8;
	localparam int RST_CYC   = 4;
	localparam int READY_LIM = 64;     // Flush, hold and a 37 deep fill
	localparam int RUN_FULL  = 100;
	localparam int RUN_GAPS  = 400;
	localparam int RUN_SEG   = 200;
	localparam int RUN_TPLS  = 200;
	localparam int RUN_PAR   = 200;
	localparam int DRAIN     = 120;    // Long enough to empty a 37 deep segment
	localparam int TOTAL_CYC = RST_CYC + 3 * READY_LIM + RUN_FULL + RUN_GAPS + RUN_SEG +
	                           RUN_TPLS + RUN_PAR + 3 * DRAIN + 2;

	logic                  CLK160;
	logic                  trst;
	depth_t                pdepth;
	logic                  restart;
	logic [NUM_SEG-1:0]    seg_restart;
	logic                  sel_tpls;
	logic                  inj_pulse;
	logic                  inj_parity;
	logic [NUM_SEG-1:0]    sample_valid;
	sample_t [NUM_SEG-1:0] sample_data;
	logic [NUM_SEG-1:0]    pip_valid;
	sample_t [NUM_SEG-1:0] pip_data;
	occ_t [NUM_SEG-1:0]    occupancy;
	logic [NUM_SEG-1:0]    pipe_ready;
	logic [NUM_SEG-1:0]    parity_err;
	logic [NUM_SEG-1:0]    model_err;
	integer                seed;
	logic                  gaps_on;    // Random idle cycles between strobes
	logic                  par_on;     // Random parity injection

	pipeline_gen #(.NUM_SEG(NUM_SEG)) UUT (
		.CLK160       (CLK160),
		.trst         (trst),
		.pdepth       (pdepth),
		.restart      (restart),
		.seg_restart  (seg_restart),
		.sel_tpls     (sel_tpls),
		.inj_pulse    (inj_pulse),
		.inj_parity   (inj_parity),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.pip_valid    (pip_valid),
		.pip_data     (pip_data),
		.occupancy    (occupancy),
		.pipe_ready   (pipe_ready),
		.parity_err   (parity_err)
	);

	genvar g;
	generate
		for (g = 0; g < NUM_SEG; g++) begin : g_ref
			pipe_ref_model #(.SEG(g)) u_ref (
				.CLK160       (CLK160),
				.trst         (trst),
				.restart      (restart | seg_restart[g]),
				.pdepth       (pdepth),
				.sel_tpls     (sel_tpls),
				.inj_pulse    (inj_pulse),
				.inj_parity   (inj_parity),
				.sample_valid (sample_valid[g]),
				.sample_data  (sample_data[g]),
				.pip_valid    (pip_valid[g]),
				.pip_data     (pip_data[g]),
				.occupancy    (occupancy[g]),
				.pipe_ready   (pipe_ready[g]),
				.parity_err   (parity_err[g]),
				.mismatch     (model_err[g])
			);
		end
	endgenerate

	initial begin
		CLK160 = 1'b0;
		forever #(CLK_PER / 2) CLK160 = ~CLK160;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	task automatic drive_cycle();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		for (int s = 0; s < NUM_SEG; s++) begin
			r0 = $random(seed);
			r1 = $random(seed);
			r2 = $random(seed);
			r3 = $random(seed);
			sample_data[s]  = {r0, r1, r2};
			sample_valid[s] = gaps_on ? (r3[1:0] != 2'b00) : 1'b1;
		end
		r0 = $random(seed);
		inj_pulse  = r0[0];
		inj_parity = par_on & r0[1];
		@(posedge CLK160);
		#1;                                // Inputs change just after the edge
	endtask

	task automatic run_cycles(input int n);
		repeat (n) drive_cycle();
	endtask

	task automatic wait_ready(input logic [NUM_SEG-1:0] mask);
		int n;
		n = 0;
		while ((pipe_ready & mask) != mask) begin
			if (n == READY_LIM) begin
				$display("pipe_ready did not rise within %0d cycles", READY_LIM);
				$display("Test failed");
				$fatal(1, "pipe_ready timeout");
			end else begin
				drive_cycle();
				n++;
			end
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		seed         = 32'h3fc0_cfc6;
		trst         = 1'b1;
		pdepth       = 9'd5;
		restart      = 1'b0;
		seg_restart  = '0;
		sel_tpls     = 1'b0;
		inj_pulse    = 1'b0;
		inj_parity   = 1'b0;
		sample_valid = '0;
		sample_data  = '0;
		gaps_on      = 1'b0;
		par_on       = 1'b0;
		repeat (RST_CYC) @(posedge CLK160);
		#1;
		trst = 1'b0;

		wait_ready('1);                    // Depth 5, strobe every cycle
		run_cycles(RUN_FULL);
		gaps_on = 1'b1;
		run_cycles(RUN_GAPS);

		gaps_on = 1'b0;                    // Segment 2 alone moves to depth 37
		pdepth = 9'd37;
		seg_restart[2] = 1'b1;
		drive_cycle();
		seg_restart[2] = 1'b0;
		wait_ready(4'b0100);
		gaps_on = 1'b1;
		run_cycles(RUN_SEG);

		sel_tpls = 1'b1;                   // Test pulse on bit 0
		run_cycles(RUN_TPLS);
		sel_tpls = 1'b0;
		run_cycles(DRAIN);

		par_on = 1'b1;
		run_cycles(RUN_PAR);
		par_on = 1'b0;
		run_cycles(DRAIN);

		gaps_on = 1'b0;                    // Global restart at depth 9
		pdepth = 9'd9;
		restart = 1'b1;
		drive_cycle();
		restart = 1'b0;
		wait_ready('1);
		run_cycles(DRAIN);

		if (|model_err) begin
			$display("Test failed");
			$fatal(1, "reference model mismatch");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

	always @(model_err) begin
		if (|model_err) begin
			$display("Test failed");
			$fatal(1, "reference model mismatch");
		end
	end

	initial begin
		repeat (TOTAL_CYC + 1000) @(posedge CLK160);
		$display("Run timed out after %0d cycles", TOTAL_CYC + 1000);
		$display("Test failed");
		$fatal(1, "watchdog");
	end

endmodule

// File: tests/pipe_ref_model.sv
module pipe_ref_model import pipe_pkg::*; #(
	parameter int SEG = 0
) (
	input  logic    CLK160,
	input  logic    trst,
	input  logic    restart,      // Global OR segment restart
	input  depth_t  pdepth,
	input  logic    sel_tpls,
	input  logic    inj_pulse,
	input  logic    inj_parity,
	input  logic    sample_valid,
	input  sample_t sample_data,
	input  logic    pip_valid,
	input  sample_t pip_data,
	input  occ_t    occupancy,
	input  logic    pipe_ready,
	input  logic    parity_err,
	output logic    mismatch
);

	timeunit 1ns;
	timeprecision 100ps;

	pipe_state_t ph;
	int          hold_n;
	int          fill_n;
	int          depth;            // Depth taken at the last flush
	sample_t     q_data [$];       // Words in flight, oldest first
	logic        q_par [$];        // Parity injection flag per word
	logic        s1_v;
	sample_t     s1_d;
	logic        s1_p;
	logic        s2_v;             // Word expected on the outputs
	sample_t     s2_d;
	logic        s2_p;
	logic        err_q = 1'b0;

	assign mismatch = err_q;

	task automatic report_mismatch(input string name, input sample_t exp_v, input sample_t act_v);
		$display("ERR seg%0d %s expected %h actual %h", SEG, name, exp_v, act_v);
		err_q = 1'b1;
	endtask

	//////////////////////////////
	// Expected behavior
	//////////////////////////////

	always @(posedge CLK160 or posedge trst) begin
		logic    wr;
		logic    rd;
		sample_t word;
		if (trst) begin
			ph = FLUSH;
			hold_n = 0;
			fill_n = 0;
			depth = 0;
			q_data.delete();
			q_par.delete();
			s1_v = 1'b0;
			s2_v = 1'b0;
		end else begin
			wr = sample_valid && (ph == FILL || ph == RUN);
			rd = sample_valid && (ph == RUN);
			s2_v = s1_v;                     // Second cycle is the output register
			s2_d = s1_d;
			s2_p = s1_p;
			s1_v = 1'b0;
			if (rd) begin
				s1_d = q_data.pop_front();   // Oldest word leaves first
				s1_p = q_par.pop_front();
				s1_v = 1'b1;
			end
			if (wr) begin
				word = sample_data;
				if (sel_tpls)
					word[0] = inj_pulse;
				q_data.push_back(word);
				q_par.push_back(inj_parity);
			end
			if (restart) begin
				ph = FLUSH;                  // Reads in flight are dropped
				q_data.delete();
				q_par.delete();
				s1_v = 1'b0;
				s2_v = 1'b0;
			end else begin
				case (ph)
					FLUSH: begin
						depth = int'(pdepth);
						hold_n = 0;
						fill_n = 0;
						ph = HOLD;
					end
					HOLD: begin
						if (hold_n == 3)
							ph = FILL;       // Four HOLD cycles done
						else
							hold_n++;
					end
					FILL: begin
						if (wr)
							fill_n++;
						if (fill_n == depth)
							ph = RUN;
					end
					default: ph = RUN;
				endcase
			end
		end
	end

	// Outputs are stable half a cycle after the edge
	always @(negedge CLK160) begin
		if (!trst) begin
			assert (pip_valid == s2_v)
				else report_mismatch("pip_valid", sample_t'(s2_v), sample_t'(pip_valid));
			assert (!s2_v || pip_data == s2_d)
				else report_mismatch("pip_data", s2_d, pip_data);
			assert (parity_err == (s2_v && s2_p))
				else report_mismatch("parity_err", sample_t'(s2_v && s2_p), sample_t'(parity_err));
			assert (occupancy == occ_t'(q_data.size()))
				else report_mismatch("occupancy", sample_t'(q_data.size()), sample_t'(occupancy));
			assert (pipe_ready == (ph == RUN))
				else report_mismatch("pipe_ready", sample_t'(ph == RUN), sample_t'(pipe_ready));
		end
	end

endmodule

// File: hw/pipeline_gen.sv
module pipeline_gen import pipe_pkg::*; #(
	parameter int NUM_SEG = 4
) (
	input  logic                    CLK160,
	input  logic                    trst,
	input  depth_t                  pdepth,        // Shared by all segments
	input  logic                    restart,       // Global restart
	input  logic [NUM_SEG-1:0]      seg_restart,   // Per-segment restart
	input  logic                    sel_tpls,
	input  logic                    inj_pulse,
	input  logic                    inj_parity,
	input  logic [NUM_SEG-1:0]      sample_valid,
	input  sample_t [NUM_SEG-1:0]   sample_data,
	output logic [NUM_SEG-1:0]      pip_valid,
	output sample_t [NUM_SEG-1:0]   pip_data,
	output occ_t [NUM_SEG-1:0]      occupancy,
	output logic [NUM_SEG-1:0]      pipe_ready,
	output logic [NUM_SEG-1:0]      parity_err
);

	logic [NUM_SEG-1:0] seg_rst;   // Restart seen by each segment

	assign seg_rst = seg_restart | {NUM_SEG{restart}};

	//////////////////////////////
	// Segments
	//////////////////////////////

	genvar s;
	generate
		for (s = 0; s < NUM_SEG; s++) begin : g_seg
			pipe_segment u_seg (
				.CLK160       (CLK160),
				.trst         (trst),
				.restart      (seg_rst[s]),
				.pdepth       (pdepth),
				.sel_tpls     (sel_tpls),
				.inj_pulse    (inj_pulse),
				.inj_parity   (inj_parity),
				.sample_valid (sample_valid[s]),
				.sample_data  (sample_data[s]),
				.pip_valid    (pip_valid[s]),
				.pip_data     (pip_data[s]),
				.occupancy    (occupancy[s]),
				.pipe_ready   (pipe_ready[s]),
				.parity_err   (parity_err[s])
			);
		end
	endgenerate

endmodule

// File: hw/pipe_segment.sv
module pipe_segment import pipe_pkg::*; (
	input  logic    CLK160,
	input  logic    trst,
	input  logic    restart,
	input  depth_t  pdepth,
	input  logic    sel_tpls,      // Test pulse replaces bit 0
	input  logic    inj_pulse,
	input  logic    inj_parity,
	input  logic    sample_valid,
	input  sample_t sample_data,
	output logic    pip_valid,
	output sample_t pip_data,
	output occ_t    occupancy,
	output logic    pipe_ready,
	output logic    parity_err
);

	sample_t fifo_din;
	sample_t fifo_dout;
	logic    fifo_valid;
	logic    fifo_perr;
	logic    fifo_empty;
	logic    fifo_full;
	logic    fifo_flush;
	logic    wr_en;
	logic    rd_en;
	logic    seg_clear;     // Restart edge or flush cycle
	depth_t  depth_q;       // Depth in force since the last flush

	// Test pulse mux on bit 0
	assign fifo_din = {sample_data[SAMPLE_W-1:1], sel_tpls ? inj_pulse : sample_data[0]};

	assign seg_clear = restart | fifo_flush;

	pipe_start_fsm u_fsm (
		.CLK160       (CLK160),
		.trst         (trst),
		.restart      (restart),
		.pdepth       (pdepth),
		.sample_valid (sample_valid),
		.fifo_flush   (fifo_flush),
		.wr_en        (wr_en),
		.rd_en        (rd_en),
		.pipe_ready   (pipe_ready)
	);

	sample_fifo u_fifo (
		.CLK160     (CLK160),
		.trst       (trst),
		.flush      (fifo_flush),
		.wr_en      (wr_en),
		.rd_en      (rd_en),
		.din        (fifo_din),
		.inj_parity (inj_parity),
		.dout       (fifo_dout),
		.dout_valid (fifo_valid),
		.parity_err (fifo_perr),
		.empty      (fifo_empty),
		.full       (fifo_full)
	);

	//////////////////////////////
	// Occupancy and output stage
	//////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			occupancy  <= '0;
			depth_q    <= '0;
			pip_valid  <= 1'b0;
			parity_err <= 1'b0;
		end else begin
			if (seg_clear)
				occupancy <= '0;
			else if (wr_en && !rd_en)
				occupancy <= occupancy + 1'b1;
			else if (rd_en && !wr_en)
				occupancy <= occupancy - 1'b1;
			if (fifo_flush)
				depth_q <= pdepth;
			pip_valid  <= fifo_valid & ~seg_clear;   // Drop reads cut by a restart
			parity_err <= fifo_perr & ~seg_clear;
		end
	end

	always_ff @(posedge CLK160) begin
		if (fifo_valid)
			pip_data <= fifo_dout;
	end

	a_occ_le_depth: assert property (
		@(posedge CLK160) disable iff (trst) occupancy <= occ_t'(depth_q));

	a_occ_run: assert property (
		@(posedge CLK160) disable iff (trst) pipe_ready |-> occupancy == occ_t'(depth_q));

	// Counter and FIFO pointers agree once the flush is done
	a_fifo_flags: assert property (
		@(posedge CLK160) disable iff (trst)
		!fifo_flush |-> ((occupancy == '0) == fifo_empty) && !fifo_full);

endmodule

// File: hw/pipe_start_fsm.sv
module pipe_start_fsm import pipe_pkg::*; (
	input  logic   CLK160,
	input  logic   trst,
	input  logic   restart,
	input  depth_t pdepth,
	input  logic   sample_valid,
	output logic   fifo_flush,
	output logic   wr_en,
	output logic   rd_en,
	output logic   pipe_ready
);

	pipe_state_t state;
	pipe_state_t state_nxt;
	logic [1:0]  hold_cnt;    // Counts the four HOLD cycles
	depth_t      wr_cnt;      // Writes done during FILL
	depth_t      depth_q;     // pdepth taken at the last flush
	logic        fill_done;

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign fifo_flush = (state == FLUSH);
	assign wr_en      = sample_valid && ((state == FILL) || (state == RUN));
	assign rd_en      = sample_valid && (state == RUN);
	assign pipe_ready = (state == RUN);

	// Last fill write is on this strobe
	assign fill_done = (state == FILL) && sample_valid && (wr_cnt == depth_q - 1'b1);

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			state <= FLUSH;
		else if (restart)
			state <= FLUSH;        // Restart wins from any state
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			FLUSH: state_nxt = HOLD;
			HOLD: begin
				if (hold_cnt == 2'd3)
					state_nxt = FILL;
			end
			FILL: begin
				if (fill_done)
					state_nxt = RUN;
			end
			RUN: state_nxt = RUN;     // Left only through restart
			default: state_nxt = FLUSH;
		endcase
	end

	//////////////////////////////
	// Counters
	//////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			hold_cnt <= '0;
			wr_cnt   <= '0;
			depth_q  <= '0;
		end else if (state == FLUSH) begin
			hold_cnt <= '0;
			wr_cnt   <= '0;
			depth_q  <= pdepth;    // New depth only takes hold here
		end else begin
			if (state == HOLD)
				hold_cnt <= hold_cnt + 1'b1;
			if (state == FILL && sample_valid)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// Reads only start once the full depth has been written
	a_rd_in_run: assert property (
		@(posedge CLK160) disable iff (trst)
		rd_en |-> (state == RUN) && (wr_cnt == depth_q));

	// FILL is reached only after four whole HOLD cycles
	a_hold_len: assert property (
		@(posedge CLK160) disable iff (trst)
		(state == FILL) && ($past(state) == HOLD) |-> ($past(state, 4) == HOLD));

endmodule

// File: hw/sample_fifo.sv
module sample_fifo import pipe_pkg::*; (
	input  logic    CLK160,
	input  logic    trst,
	input  logic    flush,       // Clears both pointers
	input  logic    wr_en,
	input  logic    rd_en,
	input  sample_t din,
	input  logic    inj_parity,  // Flip the stored parity bit
	output sample_t dout,
	output logic    dout_valid,
	output logic    parity_err,
	output logic    empty,
	output logic    full
);

	localparam int DEPTH = 1 << FIFO_AW;

	sample_t          mem [0:DEPTH-1];
	logic             par_mem [0:DEPTH-1];
	logic [FIFO_AW:0] wr_ptr;    // Extra bit tells full from empty
	logic [FIFO_AW:0] rd_ptr;
	logic             din_par;
	logic             dout_par;  // Stored parity of the word in dout

	// Even parity over the word, optionally corrupted
	assign din_par = (^din) ^ inj_parity;

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
	               (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

	//////////////////////////////
	// Storage and read port
	//////////////////////////////

	always_ff @(posedge CLK160) begin
		if (wr_en) begin
			mem[wr_ptr[FIFO_AW-1:0]]     <= din;
			par_mem[wr_ptr[FIFO_AW-1:0]] <= din_par;
		end
		if (rd_en) begin
			dout     <= mem[rd_ptr[FIFO_AW-1:0]];
			dout_par <= par_mem[rd_ptr[FIFO_AW-1:0]];
		end
	end

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			dout_valid <= 1'b0;
		else
			dout_valid <= rd_en;    // Word appears one cycle after rd_en
	end

	// Recompute on the word as read and compare to the stored bit
	assign parity_err = dout_valid && ((^dout) != dout_par);

	// The start FSM must never overrun or underrun the buffer
	a_no_wr_full: assert property (
		@(posedge CLK160) disable iff (trst) wr_en |-> !full);

	a_no_rd_empty: assert property (
		@(posedge CLK160) disable iff (trst) rd_en |-> !empty);

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

	//////////////////////////////
	// Sample word
	//////////////////////////////

	localparam int SAMPLE_W = 96;           // Two DAQ8CH halves of 48 bits

	typedef logic [SAMPLE_W-1:0] sample_t;  // One ADC sample word

	//////////////////////////////
	// Depth and occupancy
	//////////////////////////////

	// The FIFO must hold a full depth_t worth of words, so 512 entries
	localparam int FIFO_AW = 9;

	typedef logic [8:0] depth_t;            // Latency in strobes, 1 to 511
	typedef logic [9:0] occ_t;              // Write minus read count

	//////////////////////////////
	// Start FSM
	//////////////////////////////

	// FLUSH  clears FIFO and counters, one cycle
	// HOLD   four idle cycles after the flush
	// FILL   write only, until pdepth words are stored
	// RUN    write and read on every strobe
	typedef enum logic [1:0] {
		FLUSH,
		HOLD,
		FILL,
		RUN
	} pipe_state_t;

endpackage
